/* invaders_pkg.sv */
// ==================================================
// Shared screen geometry, pixel types, sprite start
// positions, move rates and the control state type
// ==================================================
package invaders_pkg;

  // Pixel coordinate and colour types
  typedef logic [7:0] x_t;
  typedef logic [6:0] y_t;
  typedef logic [2:0] colour_t;

  // Screen size in pixels
  localparam int SCREEN_W = 160;
  localparam int SCREEN_H = 120;

  // RGB, one bit per channel
  localparam colour_t COLOUR_BLACK  = 3'b000;
  localparam colour_t COLOUR_PLAYER = 3'b010;  // Green
  localparam colour_t COLOUR_ALIEN  = 3'b100;  // Red
  localparam colour_t COLOUR_BULLET = 3'b111;  // White

  // Player sits on a fixed row near the bottom
  localparam x_t PLAYER_X0 = 8'd68;
  localparam y_t PLAYER_Y  = 7'd111;

  // Each alien owns a 20 pixel wide column
  localparam int ALIEN_COUNT = 3;
  localparam int ALIEN_COL0  = 50;
  localparam int ALIEN_COL_W = 20;
  localparam y_t ALIEN_Y0    = 7'd15;

  // Updates per step, bullet steps on every update
  localparam int PLAYER_STEP_FRAMES = 2;
  localparam int ALIEN_STEP_FRAMES  = 4;

  // Control FSM states
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_START,
    ST_PLOT_PLAYER,
    ST_PLOT_ALIEN,
    ST_PLOT_BULLET,
    ST_WAIT_FRAME,
    ST_CLEAR,
    ST_UPDATE
  } game_state_t;

endpackage

/* game_control.sv */
// ==================================================
// Game control FSM: start, sprite plots, frame wait,
// screen clear and position update
// ==================================================
`timescale 1ns/10ps

module game_control import invaders_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       go,
  input  logic       frame_tick,
  input  logic       bullet_flying,
  input  logic       clear_done,
  output logic       in_game,
  output logic       start,
  output logic       plot_player,
  output logic       plot_alien,
  output logic       plot_bullet,
  output logic       clear_en,
  output logic       update,
  output logic [1:0] alien_sel
);

  game_state_t state;
  game_state_t state_nxt;
  logic        last_alien;

  assign last_alien = (alien_sel == 2'(ALIEN_COUNT - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:        state_nxt = go ? ST_START : ST_IDLE;
      ST_START:       state_nxt = ST_PLOT_PLAYER;
      ST_PLOT_PLAYER: state_nxt = ST_PLOT_ALIEN;
      ST_PLOT_ALIEN: begin
        // Bullet plot only while it is in the air
        if (last_alien) begin
          state_nxt = bullet_flying ? ST_PLOT_BULLET : ST_WAIT_FRAME;
        end
      end
      ST_PLOT_BULLET: state_nxt = ST_WAIT_FRAME;
      ST_WAIT_FRAME:  state_nxt = frame_tick ? ST_CLEAR : ST_WAIT_FRAME;
      ST_CLEAR:       state_nxt = clear_done ? ST_UPDATE : ST_CLEAR;
      ST_UPDATE:      state_nxt = ST_PLOT_PLAYER;
      default:        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Alien index steps once per cycle in the alien plot state
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      alien_sel <= '0;
    end else if (state == ST_PLOT_ALIEN && !last_alien) begin
      alien_sel <= alien_sel + 2'd1;
    end else begin
      alien_sel <= '0;
    end
  end

  // Moore decode of the strobes
  assign in_game     = (state != ST_IDLE);  // Never returns to idle
  assign start       = (state == ST_START);
  assign plot_player = (state == ST_PLOT_PLAYER);
  assign plot_alien  = (state == ST_PLOT_ALIEN);
  assign plot_bullet = (state == ST_PLOT_BULLET);
  assign clear_en    = (state == ST_CLEAR);
  assign update      = (state == ST_UPDATE);

  a_one_plot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({plot_player, plot_alien, plot_bullet, clear_en}));

  // Last raster point from the writer hands over to the update cycle
  a_clear_then_update: assert property (@(posedge clk) disable iff (rst)
    clear_done |=> update ##1 plot_player);

endmodule

/* frame_timer.sv */
// ==================================================
// Frame tick divider and update phase counters
// ==================================================
`timescale 1ns/10ps

module frame_timer import invaders_pkg::*; #(
  parameter int FRAME_CYCLES = 833334
) (
  input  logic clk,
  input  logic rst,
  input  logic in_game,
  input  logic start,
  input  logic update,
  output logic frame_tick,
  output logic player_move,
  output logic alien_move
);

  localparam int CNT_W = $clog2(FRAME_CYCLES + 1);
  localparam int PW    = $clog2(PLAYER_STEP_FRAMES + 1);
  localparam int AW    = $clog2(ALIEN_STEP_FRAMES + 1);

  logic [CNT_W-1:0] cycle_cnt;
  logic [PW-1:0]    player_phase;  // Updates since the last player step
  logic [AW-1:0]    alien_phase;

  assign frame_tick = in_game && (cycle_cnt == CNT_W'(FRAME_CYCLES - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cycle_cnt <= '0;
    end else if (!in_game || frame_tick) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // Update counted from 1, so a step lands on the phase before wrap
  assign player_move = (player_phase == PW'(PLAYER_STEP_FRAMES - 1));
  assign alien_move  = (alien_phase == AW'(ALIEN_STEP_FRAMES - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      player_phase <= '0;
      alien_phase  <= '0;
    end else if (start) begin
      player_phase <= '0;
      alien_phase  <= '0;
    end else if (update) begin
      player_phase <= player_move ? '0 : player_phase + 1'b1;
      alien_phase  <= alien_move ? '0 : alien_phase + 1'b1;
    end
  end

endmodule

/* player_ctrl.sv */
// ==================================================
// Player column register, stepped by the buttons
// ==================================================
`timescale 1ns/10ps

module player_ctrl import invaders_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic update,
  input  logic player_move,
  input  logic btn_left,
  input  logic btn_right,
  output x_t   player_x
);

  logic step_left;
  logic step_right;
  logic step_en;

  // Both buttons together cancel out
  assign step_left  = btn_left && !btn_right && (player_x != '0);
  assign step_right = btn_right && !btn_left && (player_x != x_t'(SCREEN_W - 1));
  assign step_en    = update && player_move;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      player_x <= PLAYER_X0;
    end else if (start) begin
      player_x <= PLAYER_X0;
    end else if (step_en) begin
      if (step_left) begin
        player_x <= player_x - 1'b1;
      end else if (step_right) begin
        player_x <= player_x + 1'b1;
      end
    end
  end

  a_on_screen: assert property (@(posedge clk) disable iff (rst)
    player_x < SCREEN_W);

endmodule

/* alien_ctrl.sv */
// ==================================================
// One alien marching inside its own column
// ==================================================
`timescale 1ns/10ps

module alien_ctrl import invaders_pkg::*; #(
  parameter int LEFT_BORDER = ALIEN_COL0
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic update,
  input  logic alien_move,
  output x_t   alien_x,
  output y_t   alien_y
);

  localparam x_t LEFT_X  = x_t'(LEFT_BORDER);
  localparam x_t RIGHT_X = x_t'(LEFT_BORDER + ALIEN_COL_W - 1);

  logic dir_right;
  logic at_edge;

  // Next step would leave the column
  assign at_edge = dir_right ? (alien_x == RIGHT_X) : (alien_x == LEFT_X);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      alien_x   <= LEFT_X;
      alien_y   <= ALIEN_Y0;
      dir_right <= 1'b1;
    end else if (start) begin
      alien_x   <= LEFT_X;
      alien_y   <= ALIEN_Y0;
      dir_right <= 1'b1;
    end else if (update && alien_move) begin
      if (at_edge) begin
        dir_right <= !dir_right;
        if (alien_y != y_t'(SCREEN_H - 1)) begin
          alien_y <= alien_y + 1'b1;  // Drop a row instead of stepping
        end
      end else if (dir_right) begin
        alien_x <= alien_x + 1'b1;
      end else begin
        alien_x <= alien_x - 1'b1;
      end
    end
  end

  a_in_column: assert property (@(posedge clk) disable iff (rst)
    (alien_x >= LEFT_X) && (alien_x <= RIGHT_X));

endmodule

/* bullet_ctrl.sv */
// ==================================================
// Player bullet: launch, rise and expiry at the top
// ==================================================
`timescale 1ns/10ps

module bullet_ctrl import invaders_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic update,
  input  logic btn_fire,
  input  x_t   player_x,
  output logic bullet_flying,
  output x_t   bullet_x,
  output y_t   bullet_y
);

  logic launch;

  assign launch = update && !bullet_flying && btn_fire;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bullet_flying <= 1'b0;
    end else if (start) begin
      bullet_flying <= 1'b0;
    end else if (update) begin
      if (bullet_flying) begin
        bullet_flying <= (bullet_y != '0);  // Gone after row 0
      end else begin
        bullet_flying <= btn_fire;
      end
    end
  end

  // Position loads on launch and climbs each update
  always_ff @(posedge clk) begin
    if (launch) begin
      bullet_x <= player_x;  // Column before the player moves
      bullet_y <= PLAYER_Y - 1'b1;
    end else if (update && bullet_flying && bullet_y != '0) begin
      bullet_y <= bullet_y - 1'b1;
    end
  end

endmodule

/* pixel_writer.sv */
// ==================================================
// Registered pixel stream mux and the clear scanner
// ==================================================
`timescale 1ns/10ps

module pixel_writer import invaders_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       plot_player,
  input  logic       plot_alien,
  input  logic       plot_bullet,
  input  logic       clear_en,
  input  logic [1:0] alien_sel,
  input  x_t         player_x,
  input  x_t         bullet_x,
  input  y_t         bullet_y,
  input  x_t         alien_x [ALIEN_COUNT],
  input  y_t         alien_y [ALIEN_COUNT],
  output x_t         pix_x,
  output y_t         pix_y,
  output colour_t    pix_colour,
  output logic       pix_plot,
  output logic       clear_done
);

  x_t   clr_x;
  y_t   clr_y;
  logic clr_row_end;
  logic clr_last;

  assign clr_row_end = (clr_x == x_t'(SCREEN_W - 1));
  assign clr_last    = clr_row_end && (clr_y == y_t'(SCREEN_H - 1));
  assign clear_done  = clear_en && clr_last;

  // Raster scan, x fastest, rewinds after the last point
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clr_x <= '0;
      clr_y <= '0;
    end else if (clear_en) begin
      if (clr_row_end) begin
        clr_x <= '0;
        clr_y <= clr_last ? '0 : clr_y + 1'b1;
      end else begin
        clr_x <= clr_x + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (plot_player) begin
      pix_x      <= player_x;
      pix_y      <= PLAYER_Y;
      pix_colour <= COLOUR_PLAYER;
    end else if (plot_alien) begin
      pix_x      <= alien_x[alien_sel];
      pix_y      <= alien_y[alien_sel];
      pix_colour <= COLOUR_ALIEN;
    end else if (plot_bullet) begin
      pix_x      <= bullet_x;
      pix_y      <= bullet_y;
      pix_colour <= COLOUR_BULLET;
    end else begin
      pix_x      <= clr_x;  // Black background point
      pix_y      <= clr_y;
      pix_colour <= COLOUR_BLACK;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pix_plot <= 1'b0;
    end else begin
      pix_plot <= plot_player || plot_alien || plot_bullet || clear_en;
    end
  end

  a_pix_on_screen: assert property (@(posedge clk) disable iff (rst)
    pix_plot |-> (pix_x < SCREEN_W) && (pix_y < SCREEN_H));

endmodule

/* space_invaders_top.sv */
// ==================================================
// Shooter engine top: control, timer, sprites, writer
// ==================================================
`timescale 1ns/10ps

module space_invaders_top import invaders_pkg::*; #(
  parameter int FRAME_CYCLES = 833334
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    go,
  input  logic    btn_left,
  input  logic    btn_right,
  input  logic    btn_fire,
  output logic    in_game,
  output logic    pix_plot,
  output x_t      pix_x,
  output y_t      pix_y,
  output colour_t pix_colour
);

  logic       start, update, clear_en, clear_done;
  logic       plot_player, plot_alien, plot_bullet;
  logic [1:0] alien_sel;
  logic       frame_tick, player_move, alien_move;
  logic       bullet_flying;
  x_t         player_x, bullet_x;
  y_t         bullet_y;
  x_t         alien_x [ALIEN_COUNT];
  y_t         alien_y [ALIEN_COUNT];

  game_control u_ctrl (
    .clk(clk), .rst(rst), .go(go),
    .frame_tick(frame_tick), .bullet_flying(bullet_flying), .clear_done(clear_done),
    .in_game(in_game), .start(start), .plot_player(plot_player),
    .plot_alien(plot_alien), .plot_bullet(plot_bullet), .clear_en(clear_en),
    .update(update), .alien_sel(alien_sel)
  );

  frame_timer #(.FRAME_CYCLES(FRAME_CYCLES)) u_timer (
    .clk(clk), .rst(rst), .in_game(in_game), .start(start), .update(update),
    .frame_tick(frame_tick), .player_move(player_move), .alien_move(alien_move)
  );

  player_ctrl u_player (
    .clk(clk), .rst(rst), .start(start), .update(update), .player_move(player_move),
    .btn_left(btn_left), .btn_right(btn_right), .player_x(player_x)
  );

  // One alien per column, left borders 20 pixels apart
  for (genvar k = 0; k < ALIEN_COUNT; k++) begin : g_alien
    alien_ctrl #(.LEFT_BORDER(ALIEN_COL0 + k * ALIEN_COL_W)) u_alien (
      .clk(clk), .rst(rst), .start(start), .update(update), .alien_move(alien_move),
      .alien_x(alien_x[k]), .alien_y(alien_y[k])
    );
  end

  bullet_ctrl u_bullet (
    .clk(clk), .rst(rst), .start(start), .update(update), .btn_fire(btn_fire),
    .player_x(player_x), .bullet_flying(bullet_flying),
    .bullet_x(bullet_x), .bullet_y(bullet_y)
  );

  pixel_writer u_writer (
    .clk(clk), .rst(rst), .plot_player(plot_player), .plot_alien(plot_alien),
    .plot_bullet(plot_bullet), .clear_en(clear_en), .alien_sel(alien_sel),
    .player_x(player_x), .bullet_x(bullet_x), .bullet_y(bullet_y),
    .alien_x(alien_x), .alien_y(alien_y),
    .pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour),
    .pix_plot(pix_plot), .clear_done(clear_done)
  );

endmodule

/* tb_space_invaders.sv */
// ==================================================
// Testbench for the shooter engine: clock, buttons,
// reference model, pixel stream compare and watchdog
// ==================================================
`timescale 1ns/10ps

module tb_space_invaders import invaders_pkg::*; ();

  localparam int FRAME_CYCLES    = 25000;
  localparam int NUM_FRAMES      = 40;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * (FRAME_CYCLES + 19300);

  logic    clk;
  logic    rst;
  logic    go;
  logic    btn_left;
  logic    btn_right;
  logic    btn_fire;
  logic    in_game;
  logic    pix_plot;
  x_t      pix_x;
  y_t      pix_y;
  colour_t pix_colour;

  integer  seed;
  bit      new_frame;     // Player pixel seen, time for new buttons
  bit      game_started;
  int      frames_done;

  // Model of the game positions, as held between updates
  x_t      m_player_x;
  x_t      m_alien_x [ALIEN_COUNT];
  y_t      m_alien_y [ALIEN_COUNT];
  logic    m_alien_dir [ALIEN_COUNT];
  logic    m_flying;
  x_t      m_bullet_x;
  y_t      m_bullet_y;
  int      update_count;

  space_invaders_top #(.FRAME_CYCLES(FRAME_CYCLES)) dut_i (
    .clk(clk), .rst(rst), .go(go),
    .btn_left(btn_left), .btn_right(btn_right), .btn_fire(btn_fire),
    .in_game(in_game), .pix_plot(pix_plot),
    .pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic report_failure(string why);
    $display("ERROR t=%0t: %s", $time, why);
    $display("sim failed");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s: got %0h expected %0h", $time, name, actual, expected);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic x_t next_player_x(x_t x, logic left, logic right, logic move);
    if (!move) return x;
    if (left && !right && x > 8'd0) return x - 8'd1;
    if (right && !left && x < x_t'(SCREEN_W - 1)) return x + 8'd1;
    return x;  // Both or none pressed
  endfunction

  // Result packed as {dir, y, x}
  function automatic logic [15:0] next_alien(x_t x, y_t y, logic dir, int left, logic move);
    int   right;
    logic at_edge;
    right = left + ALIEN_COL_W - 1;
    if (!move) return {dir, y, x};
    at_edge = dir ? (x == x_t'(right)) : (x == x_t'(left));
    if (at_edge) begin
      if (y != y_t'(SCREEN_H - 1)) y = y + 7'd1;
      return {!dir, y, x};
    end
    if (dir) return {dir, y, x + 8'd1};
    return {dir, y, x - 8'd1};
  endfunction

  // Expected {x, y, colour} at a given position of the frame stream
  function automatic logic [17:0] expected_pixel(int idx);
    int n_sprites;
    int pos;
    n_sprites = ALIEN_COUNT + 1 + (m_flying ? 1 : 0);
    if (idx == 0) return {m_player_x, PLAYER_Y, COLOUR_PLAYER};
    if (idx <= ALIEN_COUNT) return {m_alien_x[idx-1], m_alien_y[idx-1], COLOUR_ALIEN};
    if (idx < n_sprites) return {m_bullet_x, m_bullet_y, COLOUR_BULLET};
    pos = idx - n_sprites;
    return {x_t'(pos % SCREEN_W), y_t'(pos / SCREEN_W), COLOUR_BLACK};
  endfunction

  task automatic reset_model();
    int k;
    m_player_x   = PLAYER_X0;
    m_flying     = 1'b0;
    m_bullet_x   = '0;
    m_bullet_y   = '0;
    update_count = 0;
    for (k = 0; k < ALIEN_COUNT; k++) begin
      m_alien_x[k]   = x_t'(ALIEN_COL0 + k * ALIEN_COL_W);
      m_alien_y[k]   = ALIEN_Y0;
      m_alien_dir[k] = 1'b1;
    end
  endtask

  // One update step, all from the values held before it
  task automatic apply_update();
    int          k;
    logic [15:0] a;
    logic        p_move;
    logic        a_move;
    x_t          old_px;
    update_count++;
    p_move = (update_count % PLAYER_STEP_FRAMES) == 0;
    a_move = (update_count % ALIEN_STEP_FRAMES) == 0;
    old_px = m_player_x;
    m_player_x = next_player_x(m_player_x, btn_left, btn_right, p_move);
    for (k = 0; k < ALIEN_COUNT; k++) begin
      a = next_alien(m_alien_x[k], m_alien_y[k], m_alien_dir[k],
                     ALIEN_COL0 + k * ALIEN_COL_W, a_move);
      {m_alien_dir[k], m_alien_y[k], m_alien_x[k]} = a;
    end
    if (m_flying) begin
      if (m_bullet_y == '0) m_flying = 1'b0;
      else m_bullet_y = m_bullet_y - 7'd1;
    end else if (btn_fire) begin
      m_flying   = 1'b1;
      m_bullet_x = old_px;  // Launch column before the player step
      m_bullet_y = PLAYER_Y - 7'd1;
    end
  endtask

  // Outputs are registered, so the falling edge sees them settled
  initial begin : compare_stream
    int          idx;
    int          n_sprites;
    logic [17:0] exp_pix;
    idx = 0;
    forever begin
      @(negedge clk);
      if (game_started) check_value("in_game", in_game, 1);
      n_sprites = ALIEN_COUNT + 1 + (m_flying ? 1 : 0);
      if (pix_plot === 1'b1) begin
        exp_pix = expected_pixel(idx);
        check_value("pix_x", pix_x, exp_pix[17:10]);
        check_value("pix_y", pix_y, exp_pix[9:3]);
        check_value("pix_colour", pix_colour, exp_pix[2:0]);
        if (idx == 0) new_frame = 1'b1;
        if (idx == n_sprites + SCREEN_W * SCREEN_H - 1) begin
          apply_update();  // Last clear point is the frame end
          frames_done++;
          idx = 0;
        end else begin
          idx++;
        end
      end else if (idx != 0 && idx != n_sprites) begin
        report_failure("pixel stream stopped in the middle of a frame");
      end
    end
  end

  // New buttons once per frame, just after the player pixel
  initial begin : drive_buttons
    logic [31:0] rnd;
    forever begin
      @(posedge clk);
      #1;
      if (new_frame) begin
        new_frame = 1'b0;
        rnd       = $random(seed);
        btn_left  = rnd[0];
        btn_right = rnd[1];
        btn_fire  = rnd[2];
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR t=%0t: run timed out before %0d frames", $time, NUM_FRAMES);
    $display("sim failed");
    $fatal(1, "timeout");
  end

  initial begin : run_test
    int i;
    rst          = 1'b1;
    go           = 1'b0;
    btn_left     = 1'b0;
    btn_right    = 1'b0;
    btn_fire     = 1'b0;
    seed         = 32'he790dbfd;
    new_frame    = 1'b0;
    game_started = 1'b0;
    frames_done  = 0;
    reset_model();
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;

    // Idle with go low, nothing may be written
    repeat (10) begin
      @(negedge clk);
      check_value("pix_plot", pix_plot, 0);
      check_value("in_game", in_game, 0);
    end

    @(posedge clk);
    #1 go = 1'b1;
    i = 0;
    while (in_game !== 1'b1 && i < 4) begin
      @(negedge clk);
      i++;
    end
    if (in_game !== 1'b1) report_failure("in_game did not rise after go");
    game_started = 1'b1;

    while (frames_done < NUM_FRAMES) @(negedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

/* filelist.f */
invaders_pkg.sv
game_control.sv
frame_timer.sv
player_ctrl.sv
alien_ctrl.sv
bullet_ctrl.sv
pixel_writer.sv
space_invaders_top.sv
tb_space_invaders.sv

/* Makefile */
TOP = tb_space_invaders

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
